// File: vlog.f
common/sys_pkg.sv
common/sys_retire_if.sv
csr/csr_file.sv
rtl/sys_pipe.sv
rtl/sys_unit_top.sv
testbench/sys_unit_properties.sv
testbench/tb_sys_unit.sv

// File: Bender.yml
package:
  name: sys_unit

sources:
  - common/sys_pkg.sv
  - common/sys_retire_if.sv
  - csr/csr_file.sv
  - rtl/sys_pipe.sv
  - rtl/sys_unit_top.sv
  - target: test
    files:
      - testbench/sys_unit_properties.sv
      - testbench/tb_sys_unit.sv

// File: testbench/tb_sys_unit.sv
/* testbench for the system unit with clock and reset, CSR stimulus against a
   shadow register model, a comparator on the outputs and the run report. */
`timescale 1ns/10ps

module tb_sys_unit;
  import sys_pkg::*;

  localparam int vaddr_width_lp = 39;
  localparam logic [63:0] irq_mask_lp = (64'h1 << irq_software_bit_gp)
                                      | (64'h1 << irq_timer_bit_gp)
                                      | (64'h1 << irq_external_bit_gp);
  localparam logic [63:0] mie_mask_lp = 64'h1 << mstatus_mie_bit_gp;

  logic                      clk_i, arst_n_i, issue_v_i, retire_v_i;
  logic [31:0]               instr_i;
  logic [vaddr_width_lp-1:0] pc_i, commit_npc_o;
  logic [63:0]               rs1_i, imm_i, retire_data_i, data_o;
  exc_code_e                 retire_exc_i;
  logic                      iwb_fflags_v_i, fwb_fflags_v_i;
  logic [4:0]                iwb_fflags_i, fwb_fflags_i;
  logic                      timer_irq_i, software_irq_i, external_irq_i;
  logic                      illegal_instr_o, v_o, commit_v_o, commit_trap_o, irq_pending_o;
  logic [2:0]                frm_o;

  logic [63:0]               shadow [0:4095];
  logic [vaddr_width_lp-1:0] pc_cnt;
  // slot 0 was issued in the last step, slot 1 retires in this one.
  logic                      p_ret [0:1];
  logic [2:0]                p_op [0:1];
  logic [11:0]               p_addr [0:1];
  logic [63:0]               p_opnd [0:1];
  logic [3:0]                p_exc [0:1];
  logic [vaddr_width_lp-1:0] p_pc [0:1];
  logic [vaddr_width_lp-1:0] p_vaddr [0:1];
  logic                      chk_issue, exp_illegal, chk_commit, exp_trap;
  logic [63:0]               exp_data;
  logic [vaddr_width_lp-1:0] exp_npc;
  logic [2:0]                irq_lines;
  logic                      iwb_v_n, fwb_v_n;
  logic [4:0]                iwb_n, fwb_n;
  int                        errors, err_mark, tests;
  int unsigned               seed_val;

  sys_unit_top #(.vaddr_width_p(vaddr_width_lp)) dut0 (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  function automatic logic [63:0] rand64();
    return {$urandom, $urandom};
  endfunction

  function automatic logic [63:0] sext_va(input logic [vaddr_width_lp-1:0] v);
    return {{(64-vaddr_width_lp){v[vaddr_width_lp-1]}}, v};
  endfunction

  function automatic logic csr_known(input logic [11:0] addr);
    case (addr)
      csr_addr_fflags_gp, csr_addr_frm_gp, csr_addr_fcsr_gp, csr_addr_mstatus_gp,
      csr_addr_mie_gp, csr_addr_mtvec_gp, csr_addr_mscratch_gp, csr_addr_mepc_gp,
      csr_addr_mcause_gp, csr_addr_mtval_gp, csr_addr_mip_gp, csr_addr_minstret_gp:
        return 1'b1;
      default:
        return 1'b0;
    endcase
  endfunction

  function automatic logic [63:0] read_shadow(input logic [11:0] addr);
    if (addr == csr_addr_fcsr_gp)
      return {56'h0, shadow[csr_addr_frm_gp][2:0], shadow[csr_addr_fflags_gp][4:0]};
    return shadow[addr];
  endfunction

  // old value, legality and next value of one CSR access.
  function automatic void csr_model(input logic [2:0] op, input logic [11:0] addr,
                                    input logic [63:0] opnd, output logic [63:0] old_v,
                                    output logic ill, output logic [63:0] new_v,
                                    output logic wr);
    csr_addr_u a;
    a.flat = addr;
    old_v = csr_known(addr) ? read_shadow(addr) : 64'h0;
    wr = (op == e_csrrw) || (op == e_csrrwi) || (opnd != 64'h0);  // zero set or clear reads.
    ill = !csr_known(addr)
       || (wr && ((a.f.access == csr_access_ro_gp) || (addr == csr_addr_mip_gp)));
    case (op)
      e_csrrs, e_csrrsi: new_v = old_v | opnd;
      e_csrrc, e_csrrci: new_v = old_v & ~opnd;
      default:           new_v = opnd;
    endcase
  endfunction

  function automatic void store_csr(input logic [11:0] addr, input logic [63:0] val);
    case (addr)
      csr_addr_mtvec_gp, csr_addr_mepc_gp, csr_addr_mtval_gp:
        shadow[addr] = sext_va(val[vaddr_width_lp-1:0]);
      csr_addr_mie_gp:     shadow[addr] = val & irq_mask_lp;
      csr_addr_mstatus_gp: shadow[addr] = val & mie_mask_lp;
      csr_addr_mcause_gp:  shadow[addr] = val & 64'hf;
      csr_addr_fflags_gp:  shadow[addr] = val & 64'h1f;
      csr_addr_frm_gp:     shadow[addr] = val & 64'h7;
      csr_addr_fcsr_gp:
      begin
        shadow[csr_addr_fflags_gp] = val & 64'h1f;  // fcsr is frm over fflags.
        shadow[csr_addr_frm_gp]    = (val >> 5) & 64'h7;
      end
      default:             shadow[addr] = val;
    endcase
  endfunction

  function automatic void retire_model();
    logic [63:0] old_v, new_v;
    logic        ill, wr;
    if (p_exc[1] == 4'd0)
    begin
      shadow[csr_addr_minstret_gp] = shadow[csr_addr_minstret_gp] + 64'd1;
      csr_model(p_op[1], p_addr[1], p_opnd[1], old_v, ill, new_v, wr);
      if (wr)
        store_csr(p_addr[1], new_v);
    end
    else
    begin
      shadow[csr_addr_mepc_gp]    = sext_va(p_pc[1]);
      shadow[csr_addr_mcause_gp]  = 64'(p_exc[1]);
      shadow[csr_addr_mtval_gp]   = sext_va(p_vaddr[1]);
      shadow[csr_addr_mstatus_gp] = shadow[csr_addr_mstatus_gp] & ~mie_mask_lp;
    end
  endfunction

  // one clock of stimulus with a new issue and the retire of the issue two steps back.
  task automatic step(input logic iv, input logic [2:0] op, input logic [11:0] addr,
                      input logic [63:0] rs1, input logic [63:0] imm,
                      input logic [3:0] exc, input logic ret);
    logic [63:0] old_v, new_v, opnd, va;
    logic        ill, wr;
    opnd = op[2] ? imm : rs1;
    va = rs1 + imm;
    csr_model(op, addr, opnd, old_v, ill, new_v, wr);
    @(posedge clk_i);
    issue_v_i      <= iv;
    instr_i        <= {addr, 5'd1, op, 5'd2, opcode_system_gp};
    pc_i           <= pc_cnt;
    rs1_i          <= rs1;
    imm_i          <= imm;
    chk_issue      <= iv;
    exp_data       <= old_v;
    exp_illegal    <= iv && ill;
    retire_v_i     <= p_ret[1];
    retire_exc_i   <= exc_code_e'(p_exc[1]);
    chk_commit     <= p_ret[1];
    exp_trap       <= p_ret[1] && (p_exc[1] != 4'd0);
    exp_npc        <= (p_exc[1] != 4'd0) ? shadow[csr_addr_mtvec_gp][vaddr_width_lp-1:0]
                                         : p_pc[1] + 39'd4;
    {external_irq_i, timer_irq_i, software_irq_i} <= irq_lines;
    iwb_fflags_v_i <= iwb_v_n;
    iwb_fflags_i   <= iwb_n;
    fwb_fflags_v_i <= fwb_v_n;
    fwb_fflags_i   <= fwb_n;
    if (p_ret[1])
      retire_model();
    if (iwb_v_n)
      shadow[csr_addr_fflags_gp] = shadow[csr_addr_fflags_gp] | 64'(iwb_n);
    if (fwb_v_n)
      shadow[csr_addr_fflags_gp] = shadow[csr_addr_fflags_gp] | 64'(fwb_n);
    iwb_v_n = 1'b0;
    fwb_v_n = 1'b0;
    p_ret[1]   = p_ret[0];
    p_op[1]    = p_op[0];
    p_addr[1]  = p_addr[0];
    p_opnd[1]  = p_opnd[0];
    p_exc[1]   = p_exc[0];
    p_pc[1]    = p_pc[0];
    p_vaddr[1] = p_vaddr[0];
    p_ret[0]   = iv && ret;
    p_op[0]    = op;
    p_addr[0]  = addr;
    p_opnd[0]  = opnd;
    p_exc[0]   = exc;
    p_pc[0]    = pc_cnt;
    p_vaddr[0] = va[vaddr_width_lp-1:0];
    pc_cnt     = pc_cnt + 39'd4;
  endtask

  task automatic idle(input int n);
    repeat (n) step(1'b0, 3'd0, 12'd0, 64'd0, 64'd0, 4'd0, 1'b0);
  endtask

  task automatic read_csr(input logic [11:0] addr);
    step(1'b1, e_csrrs, addr, 64'd0, 64'd0, 4'd0, 1'b1);
  endtask

  task automatic wait_irq(input logic level);
    int n;
    n = 0;
    while ((irq_pending_o !== level) && (n < 12))
    begin
      idle(1);
      @(negedge clk_i);
      n = n + 1;
    end
    if (irq_pending_o !== level)
    begin
      $display("irq_pending_o did not reach %0b within %0d cycles", level, n);
      errors = errors + 1;
    end
  endtask

  task automatic end_test(input string name);
    @(negedge clk_i);
    #1;
    tests = tests + 1;
    if (errors == err_mark)
      $display("test %0d %s: ok", tests, name);
    else
      $display("test %0d %s: %0d errors", tests, name, errors - err_mark);
    err_mark = errors;
  endtask

  // outputs are stable at the falling edge.
  always @(negedge clk_i)
  begin
    if (arst_n_i)
    begin
      if (chk_issue && (data_o !== exp_data))
      begin
        $display("FAIL data_o: got %h, expected %h", data_o, exp_data);
        errors = errors + 1;
      end
      if (illegal_instr_o !== exp_illegal)
      begin
        $display("FAIL illegal_instr_o: got %h, expected %h", illegal_instr_o, exp_illegal);
        errors = errors + 1;
      end
      if (v_o !== chk_issue)
      begin
        $display("FAIL v_o: got %h, expected %h", v_o, chk_issue);
        errors = errors + 1;
      end
      if ((commit_v_o !== chk_commit) || (commit_trap_o !== exp_trap))
      begin
        $display("FAIL commit_v_o/commit_trap_o: got %h/%h, expected %h/%h",
                 commit_v_o, commit_trap_o, chk_commit, exp_trap);
        errors = errors + 1;
      end
      if (chk_commit && (commit_npc_o !== exp_npc))
      begin
        $display("FAIL commit_npc_o: got %h, expected %h", commit_npc_o, exp_npc);
        errors = errors + 1;
      end
    end
  end

  initial
  begin : main
    logic [11:0] addr;
    logic [2:0]  op;
    logic [63:0] imm;
    int          i, k;
    seed_val = 32'h2c42_873b;
    void'($urandom(seed_val));
    arst_n_i = 1'b0;
    {issue_v_i, retire_v_i, iwb_fflags_v_i, fwb_fflags_v_i} = 4'b0;
    {timer_irq_i, software_irq_i, external_irq_i} = 3'b0;
    instr_i = '0;
    pc_i = '0;
    {rs1_i, imm_i, retire_data_i} = '0;
    retire_exc_i = e_exc_none;
    {iwb_fflags_i, fwb_fflags_i} = '0;
    {chk_issue, exp_illegal, chk_commit, exp_trap, exp_data, exp_npc} = '0;
    {irq_lines, iwb_v_n, fwb_v_n, iwb_n, fwb_n} = '0;
    for (i = 0; i < 4096; i++)
      shadow[i] = 64'h0;
    for (i = 0; i < 2; i++)
    begin
      {p_ret[i], p_op[i], p_addr[i], p_opnd[i], p_exc[i], p_pc[i], p_vaddr[i]} = '0;
    end
    pc_cnt = 39'h40_0000_1000;  // bit 38 set, so mepc reads sign-extend.
    {errors, err_mark, tests} = '0;
    repeat (2) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(negedge clk_i);
    if ((irq_pending_o !== 1'b0) || (commit_trap_o !== 1'b0))
    begin
      $display("irq_pending_o or commit_trap_o not low after reset");
      errors = errors + 1;
    end

    for (i = 0; i < 24; i++)
    begin
      k = $urandom % 3;
      addr = (k == 0) ? csr_addr_mscratch_gp : (k == 1) ? csr_addr_mtvec_gp : csr_addr_mie_gp;
      k = $urandom % 6;
      op = (k < 3) ? 3'(k + 1) : 3'(k + 2);
      imm = op[2] ? 64'($urandom % 32) : rand64();
      step(1'b1, op, addr, rand64(), imm, 4'd0, 1'b1);
      idle(2);
    end
    read_csr(csr_addr_mscratch_gp);
    read_csr(csr_addr_mtvec_gp);
    read_csr(csr_addr_mie_gp);
    idle(3);
    end_test("random csr operations");

    step(1'b1, e_csrrw, 12'h7c5, rand64(), 64'd0, 4'd0, 1'b0);
    step(1'b1, e_csrrs, 12'hc80, 64'd0, 64'd0, 4'd0, 1'b0);
    step(1'b1, e_csrrw, csr_addr_mip_gp, rand64() | 64'h1, 64'd0, 4'd0, 1'b0);
    step(1'b1, e_csrrci, csr_addr_mip_gp, 64'd0, 64'h5, 4'd0, 1'b0);
    read_csr(csr_addr_mip_gp);
    idle(3);
    end_test("illegal accesses");

    step(1'b1, e_csrrw, csr_addr_mtvec_gp, 64'h0000_0040_0000_0200, 64'd0, 4'd0, 1'b1);
    idle(3);
    step(1'b1, e_csrrw, csr_addr_mscratch_gp, rand64(), rand64(), 4'(e_exc_ecall), 1'b1);
    idle(3);
    read_csr(csr_addr_mepc_gp);
    read_csr(csr_addr_mcause_gp);
    read_csr(csr_addr_mtval_gp);
    read_csr(csr_addr_mscratch_gp);
    idle(3);
    // three issues in a row, the middle one traps.
    step(1'b1, e_csrrw, csr_addr_mscratch_gp, rand64(), rand64(), 4'd0, 1'b1);
    step(1'b1, e_csrrs, csr_addr_mtvec_gp, 64'd0, rand64(), 4'(e_exc_breakpoint), 1'b1);
    step(1'b1, e_csrrw, csr_addr_mie_gp, rand64(), rand64(), 4'd0, 1'b1);
    idle(3);
    read_csr(csr_addr_mepc_gp);
    read_csr(csr_addr_mcause_gp);
    read_csr(csr_addr_mtval_gp);
    read_csr(csr_addr_mscratch_gp);
    read_csr(csr_addr_mie_gp);
    idle(3);
    end_test("trap entry");

    read_csr(csr_addr_minstret_gp);
    idle(2);
    for (i = 0; i < 8; i++)
    begin
      k = $urandom % 2;
      step(1'b1, e_csrrs, csr_addr_mscratch_gp, 64'd0, rand64(),
           (k != 0) ? 4'(e_exc_load_misaligned) : 4'd0, 1'b1);
    end
    idle(3);
    read_csr(csr_addr_minstret_gp);
    idle(3);
    end_test("minstret count");

    step(1'b1, e_csrrw, csr_addr_mie_gp, irq_mask_lp, 64'd0, 4'd0, 1'b1);
    idle(3);
    step(1'b1, e_csrrsi, csr_addr_mstatus_gp, 64'd0, mie_mask_lp, 4'd0, 1'b1);
    idle(3);
    for (i = 0; i < 3; i++)
    begin
      irq_lines = 3'b001 << i;
      wait_irq(1'b1);
      irq_lines = 3'b000;
      wait_irq(1'b0);
    end
    irq_lines = 3'b100;
    wait_irq(1'b1);
    step(1'b1, e_csrrci, csr_addr_mstatus_gp, 64'd0, mie_mask_lp, 4'd0, 1'b1);
    wait_irq(1'b0);
    irq_lines = 3'b000;
    idle(3);
    end_test("interrupt pending");

    for (i = 0; i < 16; i++)
    begin
      iwb_v_n = 1'($urandom % 2);
      iwb_n   = 5'($urandom);
      fwb_v_n = 1'($urandom % 2);
      fwb_n   = 5'($urandom);
      idle(1);
    end
    read_csr(csr_addr_fflags_gp);
    read_csr(csr_addr_fcsr_gp);
    // a nonzero rounding mode, so frm_o must move away from its reset value.
    step(1'b1, e_csrrwi, csr_addr_frm_gp, 64'd0, 64'(1 + $urandom % 7), 4'd0, 1'b1);
    idle(3);
    read_csr(csr_addr_fcsr_gp);
    @(negedge clk_i);
    if (frm_o !== shadow[csr_addr_frm_gp][2:0])
    begin
      $display("FAIL frm_o: got %h, expected %h", frm_o, shadow[csr_addr_frm_gp][2:0]);
      errors = errors + 1;
    end
    idle(3);
    end_test("fflags and frm");

    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// File: testbench/sys_unit_properties.sv
/* concurrent checks on the commit and interrupt outputs of the system pipe,
   bound into sys_pipe. */
`timescale 1ns/10ps

module sys_unit_properties (
  input logic clk_i,
  input logic arst_n_i,
  input logic retire_v_i,
  input logic commit_v_i,
  input logic commit_trap_i,
  input logic irq_pending_i
);

  // commit is a plain copy of the retire strobe.
  property commit_follows_retire;
    @(posedge clk_i) disable iff (!arst_n_i) commit_v_i == retire_v_i;
  endproperty

  property trap_needs_commit;
    @(posedge clk_i) disable iff (!arst_n_i) commit_trap_i |-> commit_v_i;
  endproperty

  property irq_low_after_reset;
    @(posedge clk_i) $rose(arst_n_i) |-> !irq_pending_i;
  endproperty

  commit_follows_retire_a: assert property (commit_follows_retire)
    else $error("commit_v_o differs from retire_v_i");

  trap_needs_commit_a: assert property (trap_needs_commit)
    else $error("commit_trap_o raised without commit_v_o");

  irq_low_after_reset_a: assert property (irq_low_after_reset)
    else $error("irq_pending_o high in the first cycle after reset");

endmodule

bind sys_pipe sys_unit_properties props0 (
  .clk_i         (clk_i),
  .arst_n_i      (arst_n_i),
  .retire_v_i    (retire_v_i),
  .commit_v_i    (commit_v_o),
  .commit_trap_i (commit_trap_o),
  .irq_pending_i (irq_pending_o)
);

// File: rtl/sys_unit_top.sv
/* top level of the system unit with plain ports around the system pipe. */
`timescale 1ns/10ps

module sys_unit_top #(
  parameter int vaddr_width_p = 39
) (
  input  logic                                 clk_i,
  input  logic                                 arst_n_i,
  input  logic                                 issue_v_i,
  input  logic [sys_pkg::instr_width_gp-1:0]   instr_i,
  input  logic [vaddr_width_p-1:0]             pc_i,
  input  logic [sys_pkg::dword_width_gp-1:0]   rs1_i,
  input  logic [sys_pkg::dword_width_gp-1:0]   imm_i,
  input  logic                                 retire_v_i,
  input  sys_pkg::exc_code_e                   retire_exc_i,
  input  logic [sys_pkg::dword_width_gp-1:0]   retire_data_i,
  input  logic                                 iwb_fflags_v_i,
  input  logic [sys_pkg::fflags_width_gp-1:0]  iwb_fflags_i,
  input  logic                                 fwb_fflags_v_i,
  input  logic [sys_pkg::fflags_width_gp-1:0]  fwb_fflags_i,
  input  logic                                 timer_irq_i,
  input  logic                                 software_irq_i,
  input  logic                                 external_irq_i,
  output logic [sys_pkg::dword_width_gp-1:0]   data_o,
  output logic                                 illegal_instr_o,
  output logic                                 v_o,
  output logic                                 commit_v_o,
  output logic                                 commit_trap_o,
  output logic [vaddr_width_p-1:0]             commit_npc_o,
  output logic                                 irq_pending_o,
  output logic [sys_pkg::frm_width_gp-1:0]     frm_o
);

  sys_pipe #(
    .vaddr_width_p(vaddr_width_p)
  ) pipe0 (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .issue_v_i       (issue_v_i),
    .instr_i         (instr_i),
    .pc_i            (pc_i),
    .rs1_i           (rs1_i),
    .imm_i           (imm_i),
    .retire_v_i      (retire_v_i),
    .retire_exc_i    (retire_exc_i),
    .retire_data_i   (retire_data_i),
    .iwb_fflags_v_i  (iwb_fflags_v_i),
    .iwb_fflags_i    (iwb_fflags_i),
    .fwb_fflags_v_i  (fwb_fflags_v_i),
    .fwb_fflags_i    (fwb_fflags_i),
    .timer_irq_i     (timer_irq_i),
    .software_irq_i  (software_irq_i),
    .external_irq_i  (external_irq_i),
    .data_o          (data_o),
    .illegal_instr_o (illegal_instr_o),
    .v_o             (v_o),
    .commit_v_o      (commit_v_o),
    .commit_trap_o   (commit_trap_o),
    .commit_npc_o    (commit_npc_o),
    .irq_pending_o   (irq_pending_o),
    .frm_o           (frm_o)
  );

endmodule

// File: rtl/sys_pipe.sv
/* system pipe: CSR command decode, a two-stage carry of pc, vaddr,
   instruction and command to the retire stage, and the CSR file. */
`timescale 1ns/10ps

module sys_pipe #(
  parameter int vaddr_width_p = 39
) (
  input  logic                                 clk_i,
  input  logic                                 arst_n_i,
  input  logic                                 issue_v_i,
  input  logic [sys_pkg::instr_width_gp-1:0]   instr_i,
  input  logic [vaddr_width_p-1:0]             pc_i,
  input  logic [sys_pkg::dword_width_gp-1:0]   rs1_i,
  input  logic [sys_pkg::dword_width_gp-1:0]   imm_i,
  input  logic                                 retire_v_i,
  input  sys_pkg::exc_code_e                   retire_exc_i,
  input  logic [sys_pkg::dword_width_gp-1:0]   retire_data_i,
  input  logic                                 iwb_fflags_v_i,
  input  logic [sys_pkg::fflags_width_gp-1:0]  iwb_fflags_i,
  input  logic                                 fwb_fflags_v_i,
  input  logic [sys_pkg::fflags_width_gp-1:0]  fwb_fflags_i,
  input  logic                                 timer_irq_i,
  input  logic                                 software_irq_i,
  input  logic                                 external_irq_i,
  output logic [sys_pkg::dword_width_gp-1:0]   data_o,
  output logic                                 illegal_instr_o,
  output logic                                 v_o,
  output logic                                 commit_v_o,
  output logic                                 commit_trap_o,
  output logic [vaddr_width_p-1:0]             commit_npc_o,
  output logic                                 irq_pending_o,
  output logic [sys_pkg::frm_width_gp-1:0]     frm_o
);
  import sys_pkg::*;

  logic [2:0]                 funct3;
  logic                       is_csr;
  logic                       csr_cmd_v;
  csr_cmd_s                   csr_cmd;
  logic [dword_width_gp-1:0]  eff_addr;
  logic [fflags_width_gp-1:0] fflags_acc;
  logic [vaddr_width_p-1:0]   pc_n_r, pc_r;
  logic [vaddr_width_p-1:0]   vaddr_n_r, vaddr_r;
  logic [instr_width_gp-1:0]  instr_n_r, instr_r;
  csr_cmd_s                   cmd_n_r, cmd_r;

  assign funct3 = instr_i[14:12];
  // funct3 of 000 and 100 are not CSR accesses.
  assign is_csr    = (instr_i[6:0] == opcode_system_gp) && (funct3[1:0] != 2'b00);
  assign csr_cmd_v = issue_v_i & is_csr;
  assign eff_addr  = rs1_i + imm_i;

  always_comb
  begin
    csr_cmd.op        = is_csr ? csr_op_e'(funct3) : e_csr_none;
    csr_cmd.addr.flat = instr_i[31:20];
    csr_cmd.data      = funct3[2] ? imm_i : rs1_i;  // immediate forms take the uimm.
  end

  assign fflags_acc = ({fflags_width_gp{iwb_fflags_v_i}} & iwb_fflags_i)
                    | ({fflags_width_gp{fwb_fflags_v_i}} & fwb_fflags_i);

  // issue lands in the _n_r stage, the retire stage sees the _r stage.
  always_ff @(posedge clk_i)
  begin
    pc_n_r    <= pc_i;
    pc_r      <= pc_n_r;
    vaddr_n_r <= eff_addr[vaddr_width_p-1:0];
    vaddr_r   <= vaddr_n_r;
    instr_n_r <= instr_i;
    instr_r   <= instr_n_r;
    cmd_n_r   <= csr_cmd_v ? csr_cmd : '0;
    cmd_r     <= cmd_n_r;
  end

  sys_retire_if #(.vaddr_width_p(vaddr_width_p)) retire_if ();

  assign retire_if.retire_v  = retire_v_i;
  assign retire_if.exception = retire_v_i ? retire_exc_i : e_exc_none;
  assign retire_if.npc       = pc_r;
  assign retire_if.vaddr     = vaddr_r;
  assign retire_if.instr     = instr_r;
  assign retire_if.data      = retire_data_i;
  assign retire_if.cmd       = cmd_r;

  csr_file #(
    .vaddr_width_p(vaddr_width_p)
  ) csr0 (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .csr_cmd_i      (csr_cmd),
    .csr_cmd_v_i    (csr_cmd_v),
    .retire         (retire_if),
    .fflags_acc_i   (fflags_acc),
    .fflags_acc_v_i (iwb_fflags_v_i | fwb_fflags_v_i),
    .timer_irq_i    (timer_irq_i),
    .software_irq_i (software_irq_i),
    .external_irq_i (external_irq_i),
    .csr_data_o     (data_o),
    .csr_illegal_o  (illegal_instr_o),
    .commit_v_o     (commit_v_o),
    .commit_trap_o  (commit_trap_o),
    .commit_npc_o   (commit_npc_o),
    .irq_pending_o  (irq_pending_o),
    .frm_o          (frm_o)
  );

  assign v_o = issue_v_i;

endmodule

// File: csr/csr_file.sv
/* machine-mode CSR file: register storage, read and legality check at issue,
   write and minstret count at retire, trap entry, interrupt pending level
   and fflags accumulation. */
`timescale 1ns/10ps

module csr_file #(
  parameter int vaddr_width_p = 39
) (
  input  logic                                 clk_i,
  input  logic                                 arst_n_i,
  input  sys_pkg::csr_cmd_s                    csr_cmd_i,
  input  logic                                 csr_cmd_v_i,
  sys_retire_if.csr                            retire,
  input  logic [sys_pkg::fflags_width_gp-1:0]  fflags_acc_i,
  input  logic                                 fflags_acc_v_i,
  input  logic                                 timer_irq_i,
  input  logic                                 software_irq_i,
  input  logic                                 external_irq_i,
  output logic [sys_pkg::dword_width_gp-1:0]   csr_data_o,
  output logic                                 csr_illegal_o,
  output logic                                 commit_v_o,
  output logic                                 commit_trap_o,
  output logic [vaddr_width_p-1:0]             commit_npc_o,
  output logic                                 irq_pending_o,
  output logic [sys_pkg::frm_width_gp-1:0]     frm_o
);
  import sys_pkg::*;

  logic                       mstatus_mie_r;
  logic [2:0]                 mie_r, mip_r;  // {external, timer, software}.
  logic [vaddr_width_p-1:0]   mtvec_r, mepc_r, mtval_r;
  logic [dword_width_gp-1:0]  mscratch_r, minstret_r;
  logic [3:0]                 mcause_r;
  logic [fflags_width_gp-1:0] fflags_r, fflags_nxt;
  logic [frm_width_gp-1:0]    frm_r;
  logic                       irq_pending_r;
  logic                       rd_hit, ro_addr;
  logic [dword_width_gp-1:0]  ret_old, ret_new;
  logic                       ret_hit, ret_wr, ret_clean, ret_trap;
  logic [vaddr_width_p-1:0]   mtval_nxt;

  function automatic logic [dword_width_gp-1:0] sext_vaddr(input logic [vaddr_width_p-1:0] v);
    return {{(dword_width_gp-vaddr_width_p){v[vaddr_width_p-1]}}, v};
  endfunction

  function automatic logic [dword_width_gp-1:0] irq_expand(input logic [2:0] bits);
    logic [dword_width_gp-1:0] w;
    w = '0;
    w[irq_software_bit_gp] = bits[0];
    w[irq_timer_bit_gp]    = bits[1];
    w[irq_external_bit_gp] = bits[2];
    return w;
  endfunction

  // set and clear with a zero operand leave the register alone.
  function automatic logic has_write(input csr_cmd_s cmd);
    return (cmd.op inside {e_csrrw, e_csrrwi})
        || ((cmd.op != e_csr_none) && (cmd.data != '0));
  endfunction

  function automatic logic [dword_width_gp-1:0] csr_read(input logic [11:0] addr,
                                                         output logic hit);
    logic [dword_width_gp-1:0] val;
    val = '0;
    hit = 1'b1;
    case (addr)
      csr_addr_fflags_gp:   val = dword_width_gp'(fflags_r);
      csr_addr_frm_gp:      val = dword_width_gp'(frm_r);
      csr_addr_fcsr_gp:     val = dword_width_gp'({frm_r, fflags_r});
      csr_addr_mstatus_gp:  val[mstatus_mie_bit_gp] = mstatus_mie_r;
      csr_addr_mie_gp:      val = irq_expand(mie_r);
      csr_addr_mip_gp:      val = irq_expand(mip_r);
      csr_addr_mtvec_gp:    val = sext_vaddr(mtvec_r);
      csr_addr_mscratch_gp: val = mscratch_r;
      csr_addr_mepc_gp:     val = sext_vaddr(mepc_r);
      csr_addr_mcause_gp:   val = dword_width_gp'(mcause_r);
      csr_addr_mtval_gp:    val = sext_vaddr(mtval_r);
      csr_addr_minstret_gp: val = minstret_r;
      default:              hit = 1'b0;
    endcase
    return val;
  endfunction

  // issue side read, same cycle.
  always_comb
  begin
    csr_data_o = csr_read(csr_cmd_i.addr.flat, rd_hit);
    // mip follows the interrupt lines only, so it is read-only here as well.
    ro_addr = (csr_cmd_i.addr.f.access == csr_access_ro_gp)
           || (csr_cmd_i.addr.flat == csr_addr_mip_gp);
    csr_illegal_o = csr_cmd_v_i & (~rd_hit | (has_write(csr_cmd_i) & ro_addr));
  end

  assign ret_clean = retire.retire_v & (retire.exception == e_exc_none);
  assign ret_trap  = retire.retire_v & (retire.exception != e_exc_none);

  always_comb
  begin
    ret_old = csr_read(retire.cmd.addr.flat, ret_hit);
    case (retire.cmd.op)
      e_csrrs, e_csrrsi: ret_new = ret_old | retire.cmd.data;
      e_csrrc, e_csrrci: ret_new = ret_old & ~retire.cmd.data;
      default:           ret_new = retire.cmd.data;
    endcase
    ret_wr = ret_clean & ret_hit & has_write(retire.cmd);
  end

  always_comb
  begin
    fflags_nxt = fflags_r;
    if (ret_wr && (retire.cmd.addr.flat inside {csr_addr_fflags_gp, csr_addr_fcsr_gp}))
    begin
      fflags_nxt = ret_new[fflags_width_gp-1:0];
    end
    if (fflags_acc_v_i)
    begin
      fflags_nxt = fflags_nxt | fflags_acc_i;
    end
  end

  // access faults report their address in the retire data.
  always_comb
  begin
    case (retire.exception)
      e_exc_illegal_instr:                   mtval_nxt = vaddr_width_p'(retire.instr);
      e_exc_load_access, e_exc_store_access: mtval_nxt = retire.data[vaddr_width_p-1:0];
      default:                               mtval_nxt = retire.vaddr;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      mstatus_mie_r <= 1'b0;
      mie_r         <= '0;
      mip_r         <= '0;
      mtvec_r       <= '0;
      mepc_r        <= '0;
      mtval_r       <= '0;
      mscratch_r    <= '0;
      minstret_r    <= '0;
      mcause_r      <= '0;
      fflags_r      <= '0;
      frm_r         <= '0;
      irq_pending_r <= 1'b0;
    end
    else
    begin
      mip_r         <= {external_irq_i, timer_irq_i, software_irq_i};
      irq_pending_r <= mstatus_mie_r & |(mie_r & mip_r);
      fflags_r      <= fflags_nxt;
      if (ret_clean)
      begin
        minstret_r <= minstret_r + 1'b1;  // a write to minstret below wins.
      end
      if (ret_wr)
      begin
        case (retire.cmd.addr.flat)
          csr_addr_frm_gp:      frm_r <= ret_new[frm_width_gp-1:0];
          csr_addr_fcsr_gp:     frm_r <= ret_new[fflags_width_gp+:frm_width_gp];
          csr_addr_mstatus_gp:  mstatus_mie_r <= ret_new[mstatus_mie_bit_gp];
          csr_addr_mie_gp:
          begin
            mie_r <= {ret_new[irq_external_bit_gp], ret_new[irq_timer_bit_gp],
                      ret_new[irq_software_bit_gp]};
          end
          csr_addr_mtvec_gp:    mtvec_r <= ret_new[vaddr_width_p-1:0];
          csr_addr_mscratch_gp: mscratch_r <= ret_new;
          csr_addr_mepc_gp:     mepc_r <= ret_new[vaddr_width_p-1:0];
          csr_addr_mcause_gp:   mcause_r <= ret_new[3:0];
          csr_addr_mtval_gp:    mtval_r <= ret_new[vaddr_width_p-1:0];
          csr_addr_minstret_gp: minstret_r <= ret_new;
          default:              ;
        endcase
      end
      if (ret_trap)
      begin
        mepc_r        <= retire.npc;
        mcause_r      <= retire.exception;
        mtval_r       <= mtval_nxt;
        mstatus_mie_r <= 1'b0;
      end
    end
  end

  assign commit_v_o    = retire.retire_v;
  assign commit_trap_o = ret_trap;
  assign commit_npc_o  = ret_trap ? mtvec_r : retire.npc + vaddr_width_p'(4);
  assign irq_pending_o = irq_pending_r;
  assign frm_o         = frm_r;

endmodule

// File: common/sys_retire_if.sv
/* retire packet carried from the system pipe to the CSR file,
   with a driver and a receiver modport. */
`timescale 1ns/10ps

interface sys_retire_if #(
  parameter int vaddr_width_p = 39
);
  import sys_pkg::*;

  logic                      retire_v;   // one-cycle strobe.
  exc_code_e                 exception;  // already masked by retire_v.
  logic [vaddr_width_p-1:0]  npc;        // pc of the retiring instruction.
  logic [vaddr_width_p-1:0]  vaddr;
  logic [instr_width_gp-1:0] instr;
  logic [dword_width_gp-1:0] data;
  csr_cmd_s                  cmd;

  modport pipe (
    output retire_v, exception, npc, vaddr, instr, data, cmd
  );

  modport csr (
    input retire_v, exception, npc, vaddr, instr, data, cmd
  );

endinterface

// File: common/sys_pkg.sv
/* shared definitions for the system pipe and the CSR file.
   widths, CSR opcodes, CSR addresses with the address union,
   retire exception codes, interrupt bit positions and the CSR command. */

package sys_pkg;

  localparam int dword_width_gp  = 64;
  localparam int instr_width_gp  = 32;
  localparam int fflags_width_gp = 5;
  localparam int frm_width_gp    = 3;

  localparam logic [6:0] opcode_system_gp = 7'b1110011;

  // values follow funct3 of the SYSTEM opcode.
  typedef enum logic [2:0] {
    e_csr_none = 3'b000,  // bubble or non-CSR instruction.
    e_csrrw    = 3'b001,
    e_csrrs    = 3'b010,
    e_csrrc    = 3'b011,
    e_csrrwi   = 3'b101,
    e_csrrsi   = 3'b110,
    e_csrrci   = 3'b111
  } csr_op_e;

  typedef struct packed {
    logic [1:0] access;  // 2'b11 marks a read-only register.
    logic [1:0] priv;
    logic [7:0] index;
  } csr_addr_fields_s;

  typedef union packed {
    logic [11:0]      flat;
    csr_addr_fields_s f;
  } csr_addr_u;

  localparam logic [1:0] csr_access_ro_gp = 2'b11;

  localparam logic [11:0] csr_addr_fflags_gp   = 12'h001;
  localparam logic [11:0] csr_addr_frm_gp      = 12'h002;
  localparam logic [11:0] csr_addr_fcsr_gp     = 12'h003;
  localparam logic [11:0] csr_addr_mstatus_gp  = 12'h300;
  localparam logic [11:0] csr_addr_mie_gp      = 12'h304;
  localparam logic [11:0] csr_addr_mtvec_gp    = 12'h305;
  localparam logic [11:0] csr_addr_mscratch_gp = 12'h340;
  localparam logic [11:0] csr_addr_mepc_gp     = 12'h341;
  localparam logic [11:0] csr_addr_mcause_gp   = 12'h342;
  localparam logic [11:0] csr_addr_mtval_gp    = 12'h343;
  localparam logic [11:0] csr_addr_mip_gp      = 12'h344;
  localparam logic [11:0] csr_addr_minstret_gp = 12'hb02;

  typedef enum logic [3:0] {
    e_exc_none             = 4'd0,
    e_exc_illegal_instr    = 4'd2,
    e_exc_breakpoint       = 4'd3,
    e_exc_load_misaligned  = 4'd4,
    e_exc_load_access      = 4'd5,
    e_exc_store_misaligned = 4'd6,
    e_exc_store_access     = 4'd7,
    e_exc_ecall            = 4'd11
  } exc_code_e;

  // positions in mie and mip.
  localparam int irq_software_bit_gp = 3;
  localparam int irq_timer_bit_gp    = 7;
  localparam int irq_external_bit_gp = 11;

  localparam int mstatus_mie_bit_gp = 3;

  typedef struct packed {
    csr_op_e                   op;
    csr_addr_u                 addr;
    logic [dword_width_gp-1:0] data;
  } csr_cmd_s;

endpackage
